// ==== core.f ====
hdl/core_pkg.sv
hdl/isa_pkg.sv
hdl/stage_queue.sv
hdl/fetch_unit.sv
hdl/inst_decoder.sv
hdl/alu.sv
hdl/execute_unit.sv
hdl/writeback_unit.sv
hdl/core.sv
testbench/core_assert.sv
testbench/core_tb.sv

// ==== Bender.yml ====
package:
  name: core

sources:
  - hdl/core_pkg.sv
  - hdl/isa_pkg.sv
  - hdl/stage_queue.sv
  - hdl/fetch_unit.sv
  - hdl/inst_decoder.sv
  - hdl/alu.sv
  - hdl/execute_unit.sv
  - hdl/writeback_unit.sv
  - hdl/core.sv
  - target: test
    files:
      - testbench/core_assert.sv
      - testbench/core_tb.sv

// ==== testbench/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;

	import core_pkg::*;
	import isa_pkg::*;

	localparam int NUM_ROWS = 45;
	localparam int NUM_TESTS = 5;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_ROW = 40;
	localparam int SETTLE_CYCLES = 20;

	logic clk;
	logic rst;
	logic i_imem_ready;
	logic i_imem_rvalid;
	inst_t i_imem_rdata;
	logic o_imem_valid;
	addr_t o_imem_addr;
	logic o_wb_valid;
	addr_t o_wb_pc;
	reg_idx_t o_wb_rd;
	word_t o_wb_data;

	// one program word per row at pc 4 * row with its expected retirement
	int row_test [NUM_ROWS];
	inst_t row_inst [NUM_ROWS];
	logic row_ret [NUM_ROWS];
	reg_idx_t row_rd [NUM_ROWS];
	word_t row_val [NUM_ROWS];
	int n_rows;

	int errors;
	int checked;
	int cur_test;
	int test_errors [NUM_TESTS + 1];
	int exp_idx;
	int nxt;

	// memory model state
	addr_t rsp_addr [$];
	int rsp_due [$];
	int seed;
	int cyc;
	int last_due;
	int due;

	core u_core (
		.clk(clk),
		.rst(rst),
		.i_imem_ready(i_imem_ready),
		.i_imem_rvalid(i_imem_rvalid),
		.i_imem_rdata(i_imem_rdata),
		.o_imem_valid(o_imem_valid),
		.o_imem_addr(o_imem_addr),
		.o_wb_valid(o_wb_valid),
		.o_wb_pc(o_wb_pc),
		.o_wb_rd(o_wb_rd),
		.o_wb_data(o_wb_data)
	);

	function automatic inst_t op_reg(input logic [6:0] f7, input logic [2:0] f3, input int rd,
			input int rs1, input int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
	endfunction

	function automatic inst_t op_imm(input logic [2:0] f3, input int rd, input int rs1,
			input int imm);
		return {12'(imm), 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
	endfunction

	function automatic inst_t lui_word(input int rd, input int imm20);
		return {20'(imm20), 5'(rd), OPC_LUI};
	endfunction

	function automatic inst_t jal_word(input int rd, input int off);
		logic [20:0] o;
		o = 21'(off);
		return {o[20], o[10:1], o[11], o[19:12], 5'(rd), OPC_JAL};
	endfunction

	function automatic inst_t branch_word(input logic [2:0] f3, input int rs1, input int rs2,
			input int off);
		logic [12:0] o;
		o = 13'(off);
		return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], OPC_BRANCH};
	endfunction

	task automatic add_row(input int test, input inst_t inst, input logic ret, input int rd,
			input word_t val);
		row_test[n_rows] = test;
		row_inst[n_rows] = inst;
		row_ret[n_rows] = ret;
		row_rd[n_rows] = reg_idx_t'(rd);
		row_val[n_rows] = val;
		n_rows++;
	endtask

	function automatic inst_t fetch_word(input addr_t addr);
		int idx;
		idx = int'(addr >> 2);
		if ((addr[1:0] == 2'b00) && (idx < n_rows)) begin
			return row_inst[idx];
		end
		// unmapped words carry an unknown opcode
		return {addr[24:0], 7'h7f} ^ {addr[31:25], 25'h0};
	endfunction

	function automatic int next_expected(input int from);
		for (int i = from; i < n_rows; i++) begin
			if (row_ret[i]) begin
				return i;
			end
		end
		return n_rows;
	endfunction

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("error at %0t: %s = %h, expected %h", $time, name, actual, expected);
			errors++;
			test_errors[cur_test]++;
		end
	endtask

	task automatic report_test(input int t);
		if (test_errors[t] == 0) begin
			$display("test %0d: ok", t);
		end else begin
			$display("test %0d: %0d mismatches", t, test_errors[t]);
		end
	endtask

	task automatic build_program();
		// alu immediate and register forms
		add_row(1, op_imm(F3_ADD, 1, 0, 5), 1, 1, 32'h5);
		add_row(1, op_imm(F3_ADD, 2, 0, -3), 1, 2, 32'hffff_fffd);
		add_row(1, op_reg(7'h00, F3_ADD, 3, 1, 2), 1, 3, 32'h2);
		add_row(1, op_reg(FUNCT7_ALT, F3_ADD, 4, 1, 2), 1, 4, 32'h8);
		add_row(1, op_reg(7'h00, F3_SLT, 5, 2, 1), 1, 5, 32'h1);
		add_row(1, op_imm(F3_SLT, 6, 1, 3), 1, 6, 32'h0);
		add_row(1, op_imm(F3_XOR, 7, 1, 'hff), 1, 7, 32'hfa);
		add_row(1, op_imm(F3_OR, 8, 1, 'h30), 1, 8, 32'h35);
		add_row(1, op_imm(F3_AND, 9, 2, 'hf0), 1, 9, 32'hf0);
		add_row(1, op_imm(F3_SLL, 10, 1, 4), 1, 10, 32'h50);
		add_row(1, op_imm(F3_SRL, 11, 2, 28), 1, 11, 32'hf);
		add_row(1, op_reg(7'h00, F3_XOR, 12, 1, 2), 1, 12, 32'hffff_fff8);
		add_row(1, op_reg(7'h00, F3_OR, 13, 1, 4), 1, 13, 32'hd);
		add_row(1, op_reg(7'h00, F3_AND, 14, 2, 4), 1, 14, 32'h8);
		add_row(1, op_reg(7'h00, F3_SLL, 15, 1, 1), 1, 15, 32'ha0);
		add_row(1, op_reg(7'h00, F3_SRL, 16, 2, 1), 1, 16, 32'h07ff_ffff);
		// raw chain
		add_row(2, op_imm(F3_ADD, 17, 0, 1), 1, 17, 32'h1);
		add_row(2, op_imm(F3_ADD, 17, 17, 2), 1, 17, 32'h3);
		add_row(2, op_reg(7'h00, F3_ADD, 17, 17, 17), 1, 17, 32'h6);
		add_row(2, op_reg(FUNCT7_ALT, F3_ADD, 18, 17, 1), 1, 18, 32'h1);
		add_row(2, op_imm(F3_SLL, 18, 18, 3), 1, 18, 32'h8);
		// wrong path words after taken branches must not retire
		add_row(3, branch_word(F3_BEQ, 1, 1, 12), 0, 0, '0);
		add_row(3, op_imm(F3_ADD, 19, 0, 99), 0, 0, '0);
		add_row(3, op_imm(F3_ADD, 19, 0, 98), 0, 0, '0);
		add_row(3, branch_word(F3_BNE, 1, 1, 8), 0, 0, '0);
		add_row(3, op_imm(F3_ADD, 19, 0, 7), 1, 19, 32'h7);
		add_row(3, branch_word(F3_BLT, 2, 1, 8), 0, 0, '0);
		add_row(3, op_imm(F3_ADD, 19, 0, 97), 0, 0, '0);
		add_row(3, branch_word(F3_BNE, 1, 2, 8), 0, 0, '0);
		add_row(3, op_imm(F3_ADD, 20, 0, 96), 0, 0, '0);
		add_row(3, branch_word(F3_BLT, 1, 2, 8), 0, 0, '0);
		add_row(3, op_imm(F3_ADD, 20, 19, 1), 1, 20, 32'h8);
		add_row(3, branch_word(F3_BEQ, 1, 2, 8), 0, 0, '0);
		add_row(3, op_imm(F3_ADD, 21, 0, 11), 1, 21, 32'hb);
		// jal links pc + 4
		add_row(4, jal_word(22, 12), 1, 22, 32'h8c);
		add_row(4, op_imm(F3_ADD, 23, 0, 1), 0, 0, '0);
		add_row(4, op_imm(F3_ADD, 23, 0, 2), 0, 0, '0);
		add_row(4, op_imm(F3_ADD, 23, 22, 4), 1, 23, 32'h90);
		// x0 and lui
		add_row(5, op_imm(F3_ADD, 0, 0, 123), 0, 0, '0);
		add_row(5, op_imm(F3_ADD, 24, 0, 0), 1, 24, 32'h0);
		add_row(5, op_reg(7'h00, F3_ADD, 25, 0, 1), 1, 25, 32'h5);
		add_row(5, lui_word(26, 'h12345), 1, 26, 32'h1234_5000);
		add_row(5, lui_word(27, 'hfffff), 1, 27, 32'hffff_f000);
		add_row(5, op_imm(F3_ADD, 27, 27, 'h7ff), 1, 27, 32'hffff_f7ff);
		// park in a self loop
		add_row(5, jal_word(0, 0), 0, 0, '0);
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// instruction memory with random ready and 1 to 3 cycles of latency
	initial begin
		i_imem_ready = 1'b0;
		i_imem_rvalid = 1'b0;
		i_imem_rdata = '0;
		seed = 41988;
		void'($urandom(seed));
		cyc = 0;
		last_due = 0;
		forever begin
			@(negedge clk);
			cyc++;
			if ((rsp_due.size() > 0) && (rsp_due[0] <= cyc)) begin
				i_imem_rvalid = 1'b1;
				i_imem_rdata = fetch_word(rsp_addr.pop_front());
				void'(rsp_due.pop_front());
			end else begin
				i_imem_rvalid = 1'b0;
			end
			i_imem_ready = ($urandom % 4) != 0;
			#1;
			if (rst && o_imem_valid && i_imem_ready) begin
				due = cyc + 1 + int'($urandom % 3);
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				rsp_addr.push_back(o_imem_addr);
				rsp_due.push_back(due);
			end
		end
	end

	initial begin
		repeat (RESET_CYCLES + NUM_ROWS * CYCLES_PER_ROW) @(posedge clk);
		$display("timeout: the program did not retire all expected instructions in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		rst = 1'b0;
		errors = 0;
		checked = 0;
		n_rows = 0;
		cur_test = 0;
		for (int t = 0; t <= NUM_TESTS; t++) begin
			test_errors[t] = 0;
		end
		build_program();
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b1;

		exp_idx = next_expected(0);
		while (exp_idx < n_rows) begin
			@(negedge clk);
			#1;
			if (o_wb_valid && (o_wb_rd != '0)) begin
				cur_test = row_test[exp_idx];
				check_value("o_wb_pc", o_wb_pc, word_t'(4 * exp_idx));
				check_value("o_wb_rd", word_t'(o_wb_rd), word_t'(row_rd[exp_idx]));
				check_value("o_wb_data", o_wb_data, row_val[exp_idx]);
				checked++;
				nxt = next_expected(exp_idx + 1);
				if ((nxt == n_rows) || (row_test[nxt] != cur_test)) begin
					report_test(cur_test);
				end
				exp_idx = nxt;
			end
		end

		// nothing else may write a register
		repeat (SETTLE_CYCLES) begin
			@(negedge clk);
			#1;
			if (o_wb_valid && (o_wb_rd != '0)) begin
				$display("unexpected write to x%0d at %0t after the last expected retirement",
					o_wb_rd, $time);
				errors++;
			end
		end

		if (u_core.u_core_assert.failures != 0) begin
			$display("%0d assertion failures", u_core.u_core_assert.failures);
			errors += u_core.u_core_assert.failures;
		end
		$display("%0d tests, %0d retirements checked, %0d errors", NUM_TESTS, checked, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== testbench/core_assert.sv ====
`timescale 1ns/10ps

module core_assert (
	input logic clk,
	input logic rst,
	input logic i_imem_valid,
	input logic i_imem_ready,
	input core_pkg::addr_t i_imem_addr,
	input logic i_redirect,
	input logic i_fq_wvalid,
	input logic i_fq_wready,
	input core_pkg::addr_t i_fq_wpc,
	input logic i_wb_valid,
	input core_pkg::reg_idx_t i_wb_rd,
	input core_pkg::word_t i_rf [core_pkg::NUM_REGS]
);

	import core_pkg::*;

	int failures = 0;

	a_addr_align: assert property (@(posedge clk) disable iff (!rst)
		i_imem_valid |-> (i_imem_addr[1:0] == 2'b00))
		else begin
			$error("instruction address not word aligned");
			failures++;
		end

	a_addr_hold: assert property (@(posedge clk) disable iff (!rst)
		i_imem_valid && !i_imem_ready |=> i_imem_valid && $stable(i_imem_addr))
		else begin
			$error("instruction request changed before it was accepted");
			failures++;
		end

	// fetch output waits for room unless a redirect discards it
	a_fq_hold: assert property (@(posedge clk) disable iff (!rst)
		i_fq_wvalid && !i_fq_wready && !i_redirect |=> i_fq_wvalid && $stable(i_fq_wpc))
		else begin
			$error("fetch queue entry lost while the queue was full");
			failures++;
		end

	// a register only changes at the edge that ends its retirement
	for (genvar r = 1; r < NUM_REGS; r++) begin : g_rf
		a_wb_rd: assert property (@(posedge clk) disable iff (!rst)
			$changed(i_rf[r]) |-> $past(i_wb_valid) && ($past(i_wb_rd) == reg_idx_t'(r)))
			else begin
				$error("x%0d changed without a retirement that names it", r);
				failures++;
			end
	end

endmodule

bind core core_assert u_core_assert (
	.clk(clk),
	.rst(rst),
	.i_imem_valid(o_imem_valid),
	.i_imem_ready(i_imem_ready),
	.i_imem_addr(o_imem_addr),
	.i_redirect(redirect),
	.i_fq_wvalid(fq_wvalid),
	.i_fq_wready(fq_wready),
	.i_fq_wpc(fq_wpc),
	.i_wb_valid(o_wb_valid),
	.i_wb_rd(o_wb_rd),
	.i_rf(u_writeback.regs)
);

// ==== hdl/core.sv ====
`timescale 1ns/10ps

module core (
	input logic clk,
	input logic rst,
	input logic i_imem_ready,
	input logic i_imem_rvalid,
	input core_pkg::inst_t i_imem_rdata,
	output logic o_imem_valid,
	output core_pkg::addr_t o_imem_addr,
	output logic o_wb_valid,
	output core_pkg::addr_t o_wb_pc,
	output core_pkg::reg_idx_t o_wb_rd,
	output core_pkg::word_t o_wb_data
);

	import core_pkg::*;
	import isa_pkg::*;

	localparam int FQ_W = $bits(addr_t) + $bits(inst_t);
	localparam int DQ_W = $bits(addr_t) + 3 * $bits(reg_idx_t) + $bits(word_t)
		+ $bits(alu_op_e) + $bits(br_kind_e) + 3;
	localparam int RQ_W = 2 * $bits(addr_t) + $bits(reg_idx_t) + $bits(word_t) + 2;

	logic redirect;
	addr_t redirect_pc;

	// fetch queue
	logic fq_room2;
	logic fq_wready;
	logic fq_wvalid;
	addr_t fq_wpc;
	inst_t fq_winst;
	logic fq_rvalid;
	addr_t fq_pc;
	inst_t fq_inst;

	// decoder outputs
	reg_idx_t id_rs1;
	reg_idx_t id_rs2;
	reg_idx_t id_rd;
	word_t id_imm;
	alu_op_e id_alu_op;
	logic id_op1_pc;
	logic id_op2_imm;
	br_kind_e id_br_kind;
	logic id_rd_en;

	// decode queue head
	logic dq_wready;
	logic dq_rvalid;
	logic dq_rready;
	addr_t dq_pc;
	reg_idx_t dq_rs1;
	reg_idx_t dq_rs2;
	reg_idx_t dq_rd;
	word_t dq_imm;
	logic [$bits(alu_op_e)-1:0] dq_alu_op;
	logic dq_op1_pc;
	logic dq_op2_imm;
	logic [$bits(br_kind_e)-1:0] dq_br_kind;
	logic dq_rd_en;

	// execute to retire queue
	reg_idx_t ex_rs1;
	reg_idx_t ex_rs2;
	word_t rd1_data;
	word_t rd2_data;
	logic rq_wready;
	logic rq_wvalid;
	addr_t ex_pc;
	reg_idx_t ex_rd;
	logic ex_rd_en;
	word_t ex_result;
	logic ex_taken;
	addr_t ex_target;

	// retire queue head
	logic rq_rvalid;
	addr_t rq_pc;
	reg_idx_t rq_rd;
	logic rq_rd_en;
	word_t rq_result;
	logic rq_taken;
	addr_t rq_target;

	fetch_unit u_fetch (
		.clk(clk),
		.rst(rst),
		.i_redirect(redirect),
		.i_redirect_pc(redirect_pc),
		.i_imem_ready(i_imem_ready),
		.i_imem_rvalid(i_imem_rvalid),
		.i_imem_rdata(i_imem_rdata),
		.i_room2(fq_room2),
		.i_wready(fq_wready),
		.o_imem_valid(o_imem_valid),
		.o_imem_addr(o_imem_addr),
		.o_wvalid(fq_wvalid),
		.o_wpc(fq_wpc),
		.o_winst(fq_winst)
	);

	stage_queue #(
		.DEPTH(FETCH_DEPTH),
		.W(FQ_W)
	) u_fetch_q (
		.clk(clk),
		.rst(rst),
		.i_flush(redirect),
		.i_wvalid(fq_wvalid),
		.i_wdata({fq_wpc, fq_winst}),
		.i_rready(dq_wready),
		.o_wready(fq_wready),
		.o_rvalid(fq_rvalid),
		.o_rdata({fq_pc, fq_inst}),
		.o_room2(fq_room2)
	);

	inst_decoder u_decoder (
		.i_inst(fq_inst),
		.o_rs1(id_rs1),
		.o_rs2(id_rs2),
		.o_rd(id_rd),
		.o_imm(id_imm),
		.o_alu_op(id_alu_op),
		.o_op1_pc(id_op1_pc),
		.o_op2_imm(id_op2_imm),
		.o_br_kind(id_br_kind),
		.o_rd_en(id_rd_en)
	);

	stage_queue #(
		.DEPTH(DECODE_DEPTH),
		.W(DQ_W)
	) u_decode_q (
		.clk(clk),
		.rst(rst),
		.i_flush(redirect),
		.i_wvalid(fq_rvalid),
		.i_wdata({fq_pc, id_rs1, id_rs2, id_rd, id_imm, id_alu_op, id_op1_pc, id_op2_imm,
			id_br_kind, id_rd_en}),
		.i_rready(dq_rready),
		.o_wready(dq_wready),
		.o_rvalid(dq_rvalid),
		.o_rdata({dq_pc, dq_rs1, dq_rs2, dq_rd, dq_imm, dq_alu_op, dq_op1_pc, dq_op2_imm,
			dq_br_kind, dq_rd_en}),
		.o_room2()
	);

	execute_unit u_execute (
		.i_rvalid(dq_rvalid),
		.i_pc(dq_pc),
		.i_rs1(dq_rs1),
		.i_rs2(dq_rs2),
		.i_rd(dq_rd),
		.i_imm(dq_imm),
		.i_alu_op(alu_op_e'(dq_alu_op)),
		.i_op1_pc(dq_op1_pc),
		.i_op2_imm(dq_op2_imm),
		.i_br_kind(br_kind_e'(dq_br_kind)),
		.i_rd_en(dq_rd_en),
		.i_wready(rq_wready),
		.i_rd1_data(rd1_data),
		.i_rd2_data(rd2_data),
		.i_wb_valid(rq_rvalid),
		.i_wb_rd(rq_rd),
		.i_wb_rd_en(rq_rd_en),
		.o_rs1(ex_rs1),
		.o_rs2(ex_rs2),
		.o_rready(dq_rready),
		.o_wvalid(rq_wvalid),
		.o_pc(ex_pc),
		.o_rd(ex_rd),
		.o_rd_en(ex_rd_en),
		.o_result(ex_result),
		.o_taken(ex_taken),
		.o_target(ex_target)
	);

	// writeback drains every cycle
	stage_queue #(
		.DEPTH(RETIRE_DEPTH),
		.W(RQ_W)
	) u_retire_q (
		.clk(clk),
		.rst(rst),
		.i_flush(1'b0),
		.i_wvalid(rq_wvalid),
		.i_wdata({ex_pc, ex_rd, ex_rd_en, ex_result, ex_taken, ex_target}),
		.i_rready(1'b1),
		.o_wready(rq_wready),
		.o_rvalid(rq_rvalid),
		.o_rdata({rq_pc, rq_rd, rq_rd_en, rq_result, rq_taken, rq_target}),
		.o_room2()
	);

	writeback_unit u_writeback (
		.clk(clk),
		.rst(rst),
		.i_rvalid(rq_rvalid),
		.i_pc(rq_pc),
		.i_rd(rq_rd),
		.i_rd_en(rq_rd_en),
		.i_result(rq_result),
		.i_taken(rq_taken),
		.i_target(rq_target),
		.i_rs1(ex_rs1),
		.i_rs2(ex_rs2),
		.o_rd1_data(rd1_data),
		.o_rd2_data(rd2_data),
		.o_redirect(redirect),
		.o_redirect_pc(redirect_pc),
		.o_wb_valid(o_wb_valid),
		.o_wb_pc(o_wb_pc),
		.o_wb_rd(o_wb_rd),
		.o_wb_data(o_wb_data)
	);

endmodule

// ==== hdl/writeback_unit.sv ====
`timescale 1ns/10ps

module writeback_unit (
	input logic clk,
	input logic rst,
	input logic i_rvalid,
	input core_pkg::addr_t i_pc,
	input core_pkg::reg_idx_t i_rd,
	input logic i_rd_en,
	input core_pkg::word_t i_result,
	input logic i_taken,
	input core_pkg::addr_t i_target,
	input core_pkg::reg_idx_t i_rs1,
	input core_pkg::reg_idx_t i_rs2,
	output core_pkg::word_t o_rd1_data,
	output core_pkg::word_t o_rd2_data,
	output logic o_redirect,
	output core_pkg::addr_t o_redirect_pc,
	output logic o_wb_valid,
	output core_pkg::addr_t o_wb_pc,
	output core_pkg::reg_idx_t o_wb_rd,
	output core_pkg::word_t o_wb_data
);

	import core_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_rvalid && i_rd_en && (i_rd != '0)) begin
			regs[i_rd] <= i_result;
		end
	end

	// x0 is hardwired
	assign o_rd1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rd2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

	assign o_redirect = i_rvalid && i_taken;
	assign o_redirect_pc = i_target;

	assign o_wb_valid = i_rvalid;
	assign o_wb_pc = i_pc;
	assign o_wb_rd = i_rd_en ? i_rd : '0;
	assign o_wb_data = i_result;

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/10ps

module execute_unit (
	input logic i_rvalid,
	input core_pkg::addr_t i_pc,
	input core_pkg::reg_idx_t i_rs1,
	input core_pkg::reg_idx_t i_rs2,
	input core_pkg::reg_idx_t i_rd,
	input core_pkg::word_t i_imm,
	input isa_pkg::alu_op_e i_alu_op,
	input logic i_op1_pc,
	input logic i_op2_imm,
	input isa_pkg::br_kind_e i_br_kind,
	input logic i_rd_en,
	input logic i_wready,
	input core_pkg::word_t i_rd1_data,
	input core_pkg::word_t i_rd2_data,
	input logic i_wb_valid,
	input core_pkg::reg_idx_t i_wb_rd,
	input logic i_wb_rd_en,
	output core_pkg::reg_idx_t o_rs1,
	output core_pkg::reg_idx_t o_rs2,
	output logic o_rready,
	output logic o_wvalid,
	output core_pkg::addr_t o_pc,
	output core_pkg::reg_idx_t o_rd,
	output logic o_rd_en,
	output core_pkg::word_t o_result,
	output logic o_taken,
	output core_pkg::addr_t o_target
);

	import core_pkg::*;
	import isa_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t alu_result;
	logic stall;
	logic src_eq;
	logic src_lt;

	assign o_rs1 = i_rs1;
	assign o_rs2 = i_rs2;

	// the retiring instruction has not reached the register file yet
	assign stall = i_wb_valid && i_wb_rd_en && (i_wb_rd != '0)
		&& ((i_wb_rd == i_rs1) || (i_wb_rd == i_rs2));

	assign o_rready = i_wready && !stall;
	assign o_wvalid = i_rvalid && !stall;

	assign op_a = i_op1_pc ? i_pc : i_rd1_data;
	assign op_b = i_op2_imm ? i_imm : i_rd2_data;

	alu u_alu (
		.i_op(i_alu_op),
		.i_a(op_a),
		.i_b(op_b),
		.o_result(alu_result)
	);

	assign src_eq = (i_rd1_data == i_rd2_data);
	assign src_lt = ($signed(i_rd1_data) < $signed(i_rd2_data));

	always_comb begin
		case (i_br_kind)
			BR_BEQ: o_taken = src_eq;
			BR_BNE: o_taken = !src_eq;
			BR_BLT: o_taken = src_lt;
			BR_JAL: o_taken = 1'b1;
			default: o_taken = 1'b0;
		endcase
	end

	assign o_target = i_pc + i_imm;
	// jal links the return address
	assign o_result = (i_br_kind == BR_JAL) ? i_pc + PC_STEP : alu_result;

	assign o_pc = i_pc;
	assign o_rd = i_rd;
	assign o_rd_en = i_rd_en;

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/10ps

module alu (
	input isa_pkg::alu_op_e i_op,
	input core_pkg::word_t i_a,
	input core_pkg::word_t i_b,
	output core_pkg::word_t o_result
);

	import core_pkg::*;
	import isa_pkg::*;

	localparam int SHAMT_W = $clog2(XLEN);

	logic [SHAMT_W-1:0] shamt;

	assign shamt = i_b[SHAMT_W-1:0];

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = i_a + i_b;
			ALU_SUB: o_result = i_a - i_b;
			ALU_SLT: o_result = word_t'($signed(i_a) < $signed(i_b));
			ALU_XOR: o_result = i_a ^ i_b;
			ALU_OR: o_result = i_a | i_b;
			ALU_AND: o_result = i_a & i_b;
			ALU_SLL: o_result = i_a << shamt;
			ALU_SRL: o_result = i_a >> shamt;
			// lui
			ALU_PASS_B: o_result = i_b;
			default: o_result = '0;
		endcase
	end

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder (
	input core_pkg::inst_t i_inst,
	output core_pkg::reg_idx_t o_rs1,
	output core_pkg::reg_idx_t o_rs2,
	output core_pkg::reg_idx_t o_rd,
	output core_pkg::word_t o_imm,
	output isa_pkg::alu_op_e o_alu_op,
	output logic o_op1_pc,
	output logic o_op2_imm,
	output isa_pkg::br_kind_e o_br_kind,
	output logic o_rd_en
);

	import core_pkg::*;
	import isa_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i;
	word_t imm_u;
	word_t imm_j;
	word_t imm_b;

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];

	assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
	assign imm_u = {i_inst[31:12], 12'b0};
	assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
	assign imm_b = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};

	// unknown words fall out as an add that writes nothing
	always_comb begin
		o_rs1 = i_inst[19:15];
		o_rs2 = i_inst[24:20];
		o_rd = i_inst[11:7];
		o_imm = '0;
		o_alu_op = ALU_ADD;
		o_op1_pc = 1'b0;
		o_op2_imm = 1'b0;
		o_br_kind = BR_NONE;
		o_rd_en = 1'b0;
		case (opcode)
			OPC_LUI: begin
				o_imm = imm_u;
				o_alu_op = ALU_PASS_B;
				o_op2_imm = 1'b1;
				o_rd_en = 1'b1;
			end
			OPC_JAL: begin
				o_imm = imm_j;
				o_op1_pc = 1'b1;
				o_br_kind = BR_JAL;
				o_rd_en = 1'b1;
			end
			OPC_BRANCH: begin
				o_imm = imm_b;
				case (funct3)
					F3_BEQ: o_br_kind = BR_BEQ;
					F3_BNE: o_br_kind = BR_BNE;
					F3_BLT: o_br_kind = BR_BLT;
					default: o_br_kind = BR_NONE;
				endcase
			end
			OPC_OP_IMM: begin
				o_imm = imm_i;
				o_op2_imm = 1'b1;
				o_rd_en = 1'b1;
				case (funct3)
					F3_ADD: o_alu_op = ALU_ADD;
					F3_SLT: o_alu_op = ALU_SLT;
					F3_XOR: o_alu_op = ALU_XOR;
					F3_OR: o_alu_op = ALU_OR;
					F3_AND: o_alu_op = ALU_AND;
					F3_SLL: begin
						o_alu_op = ALU_SLL;
						o_rd_en = (funct7 == '0);
					end
					F3_SRL: begin
						o_alu_op = ALU_SRL;
						o_rd_en = (funct7 == '0);
					end
					default: o_rd_en = 1'b0;
				endcase
			end
			OPC_OP: begin
				o_rd_en = (funct7 == '0);
				case (funct3)
					F3_ADD: begin
						if (funct7 == FUNCT7_ALT) begin
							o_alu_op = ALU_SUB;
							o_rd_en = 1'b1;
						end
					end
					F3_SLT: o_alu_op = ALU_SLT;
					F3_XOR: o_alu_op = ALU_XOR;
					F3_OR: o_alu_op = ALU_OR;
					F3_AND: o_alu_op = ALU_AND;
					F3_SLL: o_alu_op = ALU_SLL;
					F3_SRL: o_alu_op = ALU_SRL;
					default: o_rd_en = 1'b0;
				endcase
			end
			default: o_rd_en = 1'b0;
		endcase
	end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit (
	input logic clk,
	input logic rst,
	input logic i_redirect,
	input core_pkg::addr_t i_redirect_pc,
	input logic i_imem_ready,
	input logic i_imem_rvalid,
	input core_pkg::inst_t i_imem_rdata,
	input logic i_room2,
	input logic i_wready,
	output logic o_imem_valid,
	output core_pkg::addr_t o_imem_addr,
	output logic o_wvalid,
	output core_pkg::addr_t o_wpc,
	output core_pkg::inst_t o_winst
);

	import core_pkg::*;

	addr_t pc;
	addr_t req_addr;
	logic active;
	logic pending;
	logic hold;
	logic drop;
	logic resp;
	logic start;
	logic accept;

	assign resp = pending && i_imem_rvalid;

	// next request may go out in the cycle the previous response lands
	assign start = active && !hold && !i_redirect && i_room2 && (!pending || i_imem_rvalid);

	// a request that was not accepted stays on the bus unchanged
	assign o_imem_valid = hold || start;
	assign o_imem_addr = hold ? req_addr : pc;
	assign accept = o_imem_valid && i_imem_ready;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= RESET_PC;
			active <= 1'b0;
			pending <= 1'b0;
			hold <= 1'b0;
			drop <= 1'b0;
			o_wvalid <= 1'b0;
		end else begin
			active <= 1'b1;
			hold <= o_imem_valid && !i_imem_ready;
			if (accept) begin
				pending <= 1'b1;
			end else if (resp) begin
				pending <= 1'b0;
			end
			if (i_redirect) begin
				pc <= i_redirect_pc;
				// whatever is still in flight belongs to the old path
				drop <= hold || (pending && !i_imem_rvalid);
				o_wvalid <= 1'b0;
			end else begin
				if (start) begin
					pc <= pc + PC_STEP;
				end
				if (resp) begin
					drop <= 1'b0;
				end
				if (resp && !drop) begin
					o_wvalid <= 1'b1;
				end else if (i_wready) begin
					o_wvalid <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			req_addr <= pc;
		end
		if (resp) begin
			o_wpc <= req_addr;
			o_winst <= i_imem_rdata;
		end
	end

endmodule

// ==== hdl/stage_queue.sv ====
`timescale 1ns/10ps

module stage_queue #(
	parameter int DEPTH = core_pkg::FETCH_DEPTH,
	parameter int W = core_pkg::XLEN
) (
	input logic clk,
	input logic rst,
	input logic i_flush,
	input logic i_wvalid,
	input logic [W-1:0] i_wdata,
	input logic i_rready,
	output logic o_wready,
	output logic o_rvalid,
	output logic [W-1:0] o_rdata,
	output logic o_room2
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);

	logic [W-1:0] mem [DEPTH];
	logic [PW-1:0] rd_ptr;
	logic [PW-1:0] wr_ptr;
	logic [CW-1:0] count;
	logic push;
	logic pop;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
		return (ptr == LAST) ? '0 : ptr + 1'b1;
	endfunction

	assign o_wready = (count != CW'(DEPTH));
	assign o_rvalid = (count != '0);
	assign o_rdata = mem[rd_ptr];
	assign o_room2 = (int'(count) + 2) <= DEPTH;

	assign push = i_wvalid && o_wready;
	assign pop = i_rready && o_rvalid;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (i_flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CW'(push) - CW'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push && !i_flush) begin
			mem[wr_ptr] <= i_wdata;
		end
	end

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// OP and OP-IMM
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// branches
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;

	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_JAL
	} br_kind_e;

endpackage

// ==== hdl/core_pkg.sv ====
package core_pkg;

	localparam int XLEN = 32;
	localparam int ILEN = 32;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS = 2 ** REG_IDX_W;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [ILEN-1:0] inst_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// entries per stage queue
	localparam int FETCH_DEPTH = 4;
	localparam int DECODE_DEPTH = 2;
	localparam int RETIRE_DEPTH = 1;

	localparam addr_t PC_STEP = addr_t'(4);
	localparam addr_t RESET_PC = '0;

endpackage
